// ==== logic/dbus_pkg.sv ====
package dbus_pkg;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int mask_w = data_w / 8; // one enable per byte

	// data memory region
	localparam logic [addr_w-1:0] dmem_base = 32'h1000_0000;
	localparam int dmem_range = 16 * 1024; // bytes
	localparam int dmem_depth = dmem_range / mask_w;
	localparam int dmem_addr_w = $clog2(dmem_depth);

	// external AXI-Lite region
	localparam logic [addr_w-1:0] ext_base = 32'h4000_0000;
	localparam int ext_range = 64 * 1024;

	localparam int route_q_depth = 2; // commands in flight through the router
	localparam int route_q_ptr_w = (route_q_depth > 1) ? $clog2(route_q_depth) : 1;
	localparam int route_q_cnt_w = $clog2(route_q_depth + 1);

	// where an accepted command went
	typedef enum logic [1:0] {
		route_none = 2'd0,
		route_dmem = 2'd1,
		route_ext = 2'd2
	} route_t;

	typedef struct packed {
		logic [addr_w-1:0] addr;
		logic read; // 0 for write
		logic [data_w-1:0] wdata;
		logic [mask_w-1:0] wmask;
	} icb_cmd_t;

	typedef struct packed {
		logic [data_w-1:0] rdata;
		logic err;
	} icb_rsp_t;

	// AXI-Lite write data beat
	typedef struct packed {
		logic [data_w-1:0] wdata;
		logic [mask_w-1:0] wstrb;
	} axil_w_t;

endpackage

// ==== logic/dmem_ram.sv ====
`timescale 1ns/100ps

module dmem_ram import dbus_pkg::*; (
	input logic clk,
	input logic en,
	input logic [mask_w-1:0] wen,
	input logic [dmem_addr_w-1:0] addr,
	input logic [data_w-1:0] din,
	output logic [data_w-1:0] dout
);

	logic [data_w-1:0] mem [dmem_depth];

	// byte lanes written independently
	always_ff @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < mask_w; i++) begin
				if (wen[i])
					mem[addr][i*8 +: 8] <= din[i*8 +: 8];
			end
		end
	end

	// read first, dout shows the word before this write
	always_ff @(posedge clk) begin
		if (en)
			dout <= mem[addr];
	end

endmodule

// ==== logic/dmem_ctrler.sv ====
`timescale 1ns/100ps

module dmem_ctrler import dbus_pkg::*; (
	input logic clk,
	input logic reset,
	input icb_cmd_t cmd,
	input logic cmd_valid,
	output logic cmd_ready,
	output icb_rsp_t rsp,
	output logic rsp_valid,
	input logic rsp_ready
);

	logic accept;
	logic rsp_fire;
	logic [addr_w-1:0] offset;
	logic [dmem_addr_w-1:0] ram_addr;
	logic [mask_w-1:0] ram_wen;
	logic [data_w-1:0] ram_dout;
	logic ram_vld; // ram dout carries a response not yet sent
	logic hold_vld; // older response parked in hold_data
	logic [data_w-1:0] hold_data;

	// a second command fits as long as the park slot is free
	assign cmd_ready = !hold_vld;
	assign accept = cmd_valid && cmd_ready;

	assign offset = cmd.addr - dmem_base;
	assign ram_addr = offset[dmem_addr_w+1:2]; // word address in region
	assign ram_wen = cmd.read ? '0 : cmd.wmask;

	dmem_ram dmem_ram_u (
		.clk(clk),
		.en(accept),
		.wen(ram_wen),
		.addr(ram_addr),
		.din(cmd.wdata),
		.dout(ram_dout)
	);

	// parked word is always the older one
	assign rsp_valid = hold_vld || ram_vld;
	assign rsp.rdata = hold_vld ? hold_data : ram_dout;
	assign rsp.err = 1'b0;
	assign rsp_fire = rsp_valid && rsp_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			ram_vld <= 1'b0;
			hold_vld <= 1'b0;
		end else if (hold_vld) begin
			// ram_vld stays set, dout still holds the newer word
			if (rsp_fire)
				hold_vld <= 1'b0;
		end else if (ram_vld && !rsp_fire) begin
			if (accept)
				hold_vld <= 1'b1; // dout gets overwritten next edge
		end else begin
			ram_vld <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold_vld && ram_vld && !rsp_fire && accept)
			hold_data <= ram_dout;
	end

endmodule

// ==== logic/dbus_router.sv ====
`timescale 1ns/100ps

module dbus_router import dbus_pkg::*; (
	input logic clk,
	input logic reset,
	input icb_cmd_t s_cmd,
	input logic s_cmd_valid,
	output logic s_cmd_ready,
	output icb_rsp_t s_rsp,
	output logic s_rsp_valid,
	input logic s_rsp_ready,
	output icb_cmd_t dmem_cmd,
	output logic dmem_cmd_valid,
	input logic dmem_cmd_ready,
	input icb_rsp_t dmem_rsp,
	input logic dmem_rsp_valid,
	output logic dmem_rsp_ready,
	output icb_cmd_t ext_cmd,
	output logic ext_cmd_valid,
	input logic ext_cmd_ready,
	input icb_rsp_t ext_rsp,
	input logic ext_rsp_valid,
	output logic ext_rsp_ready
);

	route_t cmd_route;
	route_t head_route;
	route_t route_q [route_q_depth];
	logic [route_q_ptr_w-1:0] wr_ptr;
	logic [route_q_ptr_w-1:0] rd_ptr;
	logic [route_q_cnt_w-1:0] q_cnt;
	logic q_full;
	logic q_empty;
	logic target_ready;
	logic push;
	logic pop;
	logic [addr_w-1:0] dmem_offset;
	logic [addr_w-1:0] ext_offset;

	function automatic logic [route_q_ptr_w-1:0] ptr_inc(
		input logic [route_q_ptr_w-1:0] ptr
	);
		if (ptr == route_q_ptr_w'(route_q_depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// below the base the offset wraps to a large value
	assign dmem_offset = s_cmd.addr - dmem_base;
	assign ext_offset = s_cmd.addr - ext_base;

	always_comb begin
		if (dmem_offset < addr_w'(dmem_range))
			cmd_route = route_dmem;
		else if (ext_offset < addr_w'(ext_range))
			cmd_route = route_ext;
		else
			cmd_route = route_none; // answered by the router itself
	end

	assign q_full = (q_cnt == route_q_cnt_w'(route_q_depth));
	assign q_empty = (q_cnt == '0);

	always_comb begin
		case (cmd_route)
			route_dmem: target_ready = dmem_cmd_ready;
			route_ext: target_ready = ext_cmd_ready;
			default: target_ready = 1'b1;
		endcase
	end

	assign s_cmd_ready = !q_full && target_ready;
	assign push = s_cmd_valid && s_cmd_ready;

	// payload goes to both, only valid is steered
	assign dmem_cmd = s_cmd;
	assign ext_cmd = s_cmd;
	assign dmem_cmd_valid = s_cmd_valid && !q_full && (cmd_route == route_dmem);
	assign ext_cmd_valid = s_cmd_valid && !q_full && (cmd_route == route_ext);

	assign head_route = route_q[rd_ptr];

	// only the target named at the head may answer
	always_comb begin
		s_rsp_valid = 1'b0;
		s_rsp = '{rdata: '0, err: 1'b1};
		dmem_rsp_ready = 1'b0;
		ext_rsp_ready = 1'b0;
		if (!q_empty) begin
			case (head_route)
				route_dmem: begin
					s_rsp_valid = dmem_rsp_valid;
					s_rsp = dmem_rsp;
					dmem_rsp_ready = s_rsp_ready;
				end
				route_ext: begin
					s_rsp_valid = ext_rsp_valid;
					s_rsp = ext_rsp;
					ext_rsp_ready = s_rsp_ready;
				end
				default: s_rsp_valid = 1'b1; // unmapped, error response
			endcase
		end
	end

	assign pop = s_rsp_valid && s_rsp_ready;

	always_ff @(posedge clk) begin
		if (push)
			route_q[wr_ptr] <= cmd_route;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			q_cnt <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10: q_cnt <= q_cnt + 1'b1;
				2'b01: q_cnt <= q_cnt - 1'b1;
				default: q_cnt <= q_cnt;
			endcase
		end
	end

endmodule

// ==== logic/icb_axil_bridge.sv ====
`timescale 1ns/100ps

module icb_axil_bridge import dbus_pkg::*; (
	input logic clk,
	input logic reset,
	input icb_cmd_t cmd,
	input logic cmd_valid,
	output logic cmd_ready,
	output icb_rsp_t rsp,
	output logic rsp_valid,
	input logic rsp_ready,
	output logic [addr_w-1:0] m_axi_awaddr,
	output logic m_axi_awvalid,
	input logic m_axi_awready,
	output axil_w_t m_axi_w,
	output logic m_axi_wvalid,
	input logic m_axi_wready,
	input logic [1:0] m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready,
	output logic [addr_w-1:0] m_axi_araddr,
	output logic m_axi_arvalid,
	input logic m_axi_arready,
	input logic [data_w-1:0] m_axi_rdata,
	input logic [1:0] m_axi_rresp,
	input logic m_axi_rvalid,
	output logic m_axi_rready
);

	typedef enum logic [2:0] {
		st_idle,
		st_wr, // aw and w outstanding
		st_b,
		st_ar,
		st_r,
		st_rsp // response waits for the ICB master
	} state_t;

	state_t state;
	icb_cmd_t cmd_q;
	icb_rsp_t rsp_q;
	logic accept;
	logic aw_pend;
	logic w_pend;
	logic aw_done;
	logic w_done;

	assign cmd_ready = (state == st_idle);
	assign accept = cmd_valid && cmd_ready;

	// each write channel finishes on its own ready
	assign aw_done = !aw_pend || m_axi_awready;
	assign w_done = !w_pend || m_axi_wready;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			aw_pend <= 1'b0;
			w_pend <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (accept) begin
						state <= cmd.read ? st_ar : st_wr;
						aw_pend <= !cmd.read;
						w_pend <= !cmd.read;
					end
				end
				st_wr: begin
					aw_pend <= aw_pend && !m_axi_awready;
					w_pend <= w_pend && !m_axi_wready;
					if (aw_done && w_done)
						state <= st_b;
				end
				st_b: begin
					if (m_axi_bvalid)
						state <= st_rsp;
				end
				st_ar: begin
					if (m_axi_arready)
						state <= st_r;
				end
				st_r: begin
					if (m_axi_rvalid)
						state <= st_rsp;
				end
				st_rsp: begin
					if (rsp_ready)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			cmd_q <= cmd;
		// upper resp bit set for SLVERR and DECERR
		if (state == st_b && m_axi_bvalid)
			rsp_q <= '{rdata: '0, err: m_axi_bresp[1]};
		if (state == st_r && m_axi_rvalid)
			rsp_q <= '{rdata: m_axi_rdata, err: m_axi_rresp[1]};
	end

	assign m_axi_awaddr = cmd_q.addr;
	assign m_axi_awvalid = aw_pend;
	assign m_axi_w = '{wdata: cmd_q.wdata, wstrb: cmd_q.wmask};
	assign m_axi_wvalid = w_pend;
	assign m_axi_bready = (state == st_b);
	assign m_axi_araddr = cmd_q.addr;
	assign m_axi_arvalid = (state == st_ar);
	assign m_axi_rready = (state == st_r);

	assign rsp = rsp_q;
	assign rsp_valid = (state == st_rsp);

endmodule

// ==== logic/dbus_subsys.sv ====
`timescale 1ns/100ps

module dbus_subsys import dbus_pkg::*; (
	input logic clk,
	input logic reset,
	// upstream ICB from the external master
	input icb_cmd_t s_cmd,
	input logic s_cmd_valid,
	output logic s_cmd_ready,
	output icb_rsp_t s_rsp,
	output logic s_rsp_valid,
	input logic s_rsp_ready,
	// AXI-Lite master
	output logic [addr_w-1:0] m_axi_awaddr,
	output logic m_axi_awvalid,
	input logic m_axi_awready,
	output axil_w_t m_axi_w,
	output logic m_axi_wvalid,
	input logic m_axi_wready,
	input logic [1:0] m_axi_bresp,
	input logic m_axi_bvalid,
	output logic m_axi_bready,
	output logic [addr_w-1:0] m_axi_araddr,
	output logic m_axi_arvalid,
	input logic m_axi_arready,
	input logic [data_w-1:0] m_axi_rdata,
	input logic [1:0] m_axi_rresp,
	input logic m_axi_rvalid,
	output logic m_axi_rready
);

	// router to data memory
	icb_cmd_t dmem_cmd;
	logic dmem_cmd_valid;
	logic dmem_cmd_ready;
	icb_rsp_t dmem_rsp;
	logic dmem_rsp_valid;
	logic dmem_rsp_ready;
	// router to bridge
	icb_cmd_t ext_cmd;
	logic ext_cmd_valid;
	logic ext_cmd_ready;
	icb_rsp_t ext_rsp;
	logic ext_rsp_valid;
	logic ext_rsp_ready;

	dbus_router router_u (
		.clk(clk),
		.reset(reset),
		.s_cmd(s_cmd),
		.s_cmd_valid(s_cmd_valid),
		.s_cmd_ready(s_cmd_ready),
		.s_rsp(s_rsp),
		.s_rsp_valid(s_rsp_valid),
		.s_rsp_ready(s_rsp_ready),
		.dmem_cmd(dmem_cmd),
		.dmem_cmd_valid(dmem_cmd_valid),
		.dmem_cmd_ready(dmem_cmd_ready),
		.dmem_rsp(dmem_rsp),
		.dmem_rsp_valid(dmem_rsp_valid),
		.dmem_rsp_ready(dmem_rsp_ready),
		.ext_cmd(ext_cmd),
		.ext_cmd_valid(ext_cmd_valid),
		.ext_cmd_ready(ext_cmd_ready),
		.ext_rsp(ext_rsp),
		.ext_rsp_valid(ext_rsp_valid),
		.ext_rsp_ready(ext_rsp_ready)
	);

	dmem_ctrler dmem_ctrler_u (
		.clk(clk),
		.reset(reset),
		.cmd(dmem_cmd),
		.cmd_valid(dmem_cmd_valid),
		.cmd_ready(dmem_cmd_ready),
		.rsp(dmem_rsp),
		.rsp_valid(dmem_rsp_valid),
		.rsp_ready(dmem_rsp_ready)
	);

	icb_axil_bridge bridge_u (
		.clk(clk),
		.reset(reset),
		.cmd(ext_cmd),
		.cmd_valid(ext_cmd_valid),
		.cmd_ready(ext_cmd_ready),
		.rsp(ext_rsp),
		.rsp_valid(ext_rsp_valid),
		.rsp_ready(ext_rsp_ready),
		.m_axi_awaddr(m_axi_awaddr),
		.m_axi_awvalid(m_axi_awvalid),
		.m_axi_awready(m_axi_awready),
		.m_axi_w(m_axi_w),
		.m_axi_wvalid(m_axi_wvalid),
		.m_axi_wready(m_axi_wready),
		.m_axi_bresp(m_axi_bresp),
		.m_axi_bvalid(m_axi_bvalid),
		.m_axi_bready(m_axi_bready),
		.m_axi_araddr(m_axi_araddr),
		.m_axi_arvalid(m_axi_arvalid),
		.m_axi_arready(m_axi_arready),
		.m_axi_rdata(m_axi_rdata),
		.m_axi_rresp(m_axi_rresp),
		.m_axi_rvalid(m_axi_rvalid),
		.m_axi_rready(m_axi_rready)
	);

endmodule

// ==== verification/axil_mem_model.sv ====
`timescale 1ns/100ps

module axil_mem_model import dbus_pkg::*; (
	input logic clk,
	input logic [addr_w-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input axil_w_t w,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [addr_w-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [data_w-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	localparam int ready_limit = 100;

	logic [data_w-1:0] mem [256]; // indexed by address bits 9:2
	integer seed = 23771;

	// returns at the drive point after the response transfer
	task automatic wait_taken(input logic is_read);
		int n;
		n = 0;
		#2;
		while (!(is_read ? rready : bready) && n < ready_limit) begin
			n++;
			@(posedge clk);
			#3;
		end
		if (!(is_read ? rready : bready))
			$display("axil model gave up waiting for %s", is_read ? "rready" : "bready");
		@(posedge clk);
		#1;
	endtask

	task automatic do_write();
		int da;
		int dw;
		int n;
		logic aw_done;
		logic w_done;
		logic [addr_w-1:0] a;
		axil_w_t d;
		da = $unsigned($random(seed)) % 4; // aw and w wait independently
		dw = $unsigned($random(seed)) % 4;
		n = 0;
		aw_done = 1'b0;
		w_done = 1'b0;
		while (!(aw_done && w_done) && n < ready_limit) begin
			n++;
			@(posedge clk);
			#1;
			awready = !aw_done && (da == 0);
			wready = !w_done && (dw == 0);
			if (da > 0)
				da--;
			if (dw > 0)
				dw--;
			#2;
			// a beat moves only where valid meets ready
			if (awready && awvalid) begin
				a = awaddr;
				aw_done = 1'b1;
			end
			if (wready && wvalid) begin
				d = w;
				w_done = 1'b1;
			end
		end
		@(posedge clk);
		#1;
		awready = 1'b0;
		wready = 1'b0;
		if (!(aw_done && w_done)) begin
			$display("axil model gave up waiting for awvalid or wvalid");
			return;
		end
		if (!a[15]) begin
			for (int i = 0; i < mask_w; i++)
				if (d.wstrb[i])
					mem[a[9:2]][i*8 +: 8] = d.wdata[i*8 +: 8];
		end
		bresp = a[15] ? 2'b10 : 2'b00; // SLVERR in the error window
		bvalid = 1'b1;
		wait_taken(1'b0);
		bvalid = 1'b0;
	endtask

	task automatic do_read();
		int dr;
		logic [addr_w-1:0] a;
		dr = $unsigned($random(seed)) % 4;
		repeat (dr) @(posedge clk);
		@(posedge clk);
		#1;
		arready = 1'b1;
		#2;
		a = araddr;
		@(posedge clk);
		#1;
		arready = 1'b0;
		rdata = a[15] ? '0 : mem[a[9:2]];
		rresp = a[15] ? 2'b10 : 2'b00;
		rvalid = 1'b1;
		wait_taken(1'b1);
		rvalid = 1'b0;
	endtask

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = {i[7:0] ^ 8'h5a, ~i[7:0], i[7:0], i[7:0] ^ 8'hc3};
		awready = 1'b0;
		wready = 1'b0;
		bresp = 2'b00;
		bvalid = 1'b0;
		arready = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		rvalid = 1'b0;
	end

	initial begin
		forever begin
			@(posedge clk);
			#3;
			if (awvalid)
				do_write();
		end
	end

	initial begin
		forever begin
			@(posedge clk);
			#3;
			if (arvalid)
				do_read();
		end
	end

endmodule

// ==== verification/dbus_subsys_tb.sv ====
`timescale 1ns/100ps

module dbus_subsys_tb import dbus_pkg::*; ();

	localparam int wait_limit = 200; // cycles per wait

	typedef struct packed {
		icb_cmd_t cmd;
		logic chk_rdata; // fresh dmem words have no known old value
		icb_rsp_t exp;
	} stim_row_t;

	logic clk;
	logic reset;
	icb_cmd_t s_cmd;
	logic s_cmd_valid;
	logic s_cmd_ready;
	icb_rsp_t s_rsp;
	logic s_rsp_valid;
	logic s_rsp_ready;
	logic [addr_w-1:0] m_axi_awaddr;
	logic m_axi_awvalid;
	logic m_axi_awready;
	axil_w_t m_axi_w;
	logic m_axi_wvalid;
	logic m_axi_wready;
	logic [1:0] m_axi_bresp;
	logic m_axi_bvalid;
	logic m_axi_bready;
	logic [addr_w-1:0] m_axi_araddr;
	logic m_axi_arvalid;
	logic m_axi_arready;
	logic [data_w-1:0] m_axi_rdata;
	logic [1:0] m_axi_rresp;
	logic m_axi_rvalid;
	logic m_axi_rready;

	stim_row_t rows [$];
	icb_rsp_t rsp;
	integer seed = 23771;

	dbus_subsys uut (
		.clk(clk), .reset(reset),
		.s_cmd(s_cmd), .s_cmd_valid(s_cmd_valid), .s_cmd_ready(s_cmd_ready),
		.s_rsp(s_rsp), .s_rsp_valid(s_rsp_valid), .s_rsp_ready(s_rsp_ready),
		.m_axi_awaddr(m_axi_awaddr), .m_axi_awvalid(m_axi_awvalid), .m_axi_awready(m_axi_awready),
		.m_axi_w(m_axi_w), .m_axi_wvalid(m_axi_wvalid), .m_axi_wready(m_axi_wready),
		.m_axi_bresp(m_axi_bresp), .m_axi_bvalid(m_axi_bvalid), .m_axi_bready(m_axi_bready),
		.m_axi_araddr(m_axi_araddr), .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
		.m_axi_rdata(m_axi_rdata), .m_axi_rresp(m_axi_rresp),
		.m_axi_rvalid(m_axi_rvalid), .m_axi_rready(m_axi_rready)
	);

	axil_mem_model axil_mem (
		.clk(clk),
		.awaddr(m_axi_awaddr), .awvalid(m_axi_awvalid), .awready(m_axi_awready),
		.w(m_axi_w), .wvalid(m_axi_wvalid), .wready(m_axi_wready),
		.bresp(m_axi_bresp), .bvalid(m_axi_bvalid), .bready(m_axi_bready),
		.araddr(m_axi_araddr), .arvalid(m_axi_arvalid), .arready(m_axi_arready),
		.rdata(m_axi_rdata), .rresp(m_axi_rresp), .rvalid(m_axi_rvalid), .rready(m_axi_rready)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			fail_run($sformatf("error: %s actual %h expected %h", name, actual, expected));
	endtask

	task automatic add_row(input logic [31:0] addr, input logic read, input logic [31:0] wdata,
		input logic [3:0] wmask, input logic chk, input logic [31:0] rdata, input logic err);
		stim_row_t r;
		r.cmd.addr = addr;
		r.cmd.read = read;
		r.cmd.wdata = read ? 32'h0 : wdata;
		r.cmd.wmask = read ? 4'h0 : wmask;
		r.chk_rdata = chk;
		r.exp.rdata = rdata;
		r.exp.err = err;
		rows.push_back(r);
	endtask

	function automatic icb_cmd_t read_cmd(input logic [addr_w-1:0] addr);
		icb_cmd_t c;
		c = '0;
		c.addr = addr;
		c.read = 1'b1;
		return c;
	endfunction

	// entered at the drive point, returns one after the accepting edge
	task automatic send_cmd(input icb_cmd_t c);
		int n;
		n = 0;
		s_cmd = c;
		s_cmd_valid = 1'b1;
		#2;
		while (!s_cmd_ready) begin
			n++;
			if (n > wait_limit)
				fail_run("timed out waiting for the command to be accepted");
			@(posedge clk);
			#3;
		end
		@(posedge clk);
		#1;
		s_cmd_valid = 1'b0;
		s_cmd = '0;
	endtask

	task automatic recv_rsp(output icb_rsp_t r);
		int n;
		n = 0;
		#2;
		while (!s_rsp_valid) begin
			n++;
			if (n > wait_limit)
				fail_run("timed out waiting for a response");
			@(posedge clk);
			#3;
		end
		r = s_rsp; // taken on the next edge
		@(posedge clk);
		#1;
	endtask

	task automatic pause_rsp_ready();
		int k;
		k = $unsigned($random(seed)) % 3;
		if (k > 0) begin
			s_rsp_ready = 1'b0;
			repeat (k) begin
				@(posedge clk);
				#1;
			end
			s_rsp_ready = 1'b1;
		end
	endtask

	// valid must appear in the first cycle after acceptance
	task automatic check_next_cycle_rsp(input logic [31:0] addr, input logic [31:0] rdata,
		input logic err);
		s_cmd = read_cmd(addr);
		s_cmd_valid = 1'b1;
		#2;
		check_value("s_cmd_ready", s_cmd_ready, 1'b1);
		check_value("s_rsp_valid", s_rsp_valid, 1'b0);
		@(posedge clk);
		#1;
		s_cmd_valid = 1'b0;
		#2;
		check_value("s_rsp_valid", s_rsp_valid, 1'b1);
		check_value("s_rsp.rdata", s_rsp.rdata, rdata);
		check_value("s_rsp.err", s_rsp.err, err);
		@(posedge clk);
		#1;
		#2;
		check_value("s_rsp_valid", s_rsp_valid, 1'b0);
		@(posedge clk);
		#1;
	endtask

	task automatic check_in_order();
		icb_rsp_t r;
		s_rsp_ready = 1'b0;
		send_cmd(read_cmd(32'h1000_0010));
		send_cmd(read_cmd(32'h1000_3FFC));
		s_cmd = read_cmd(32'h1000_0010);
		s_cmd_valid = 1'b1;
		repeat (3) begin
			#2;
			check_value("s_cmd_ready", s_cmd_ready, 1'b0); // two in flight
			@(posedge clk);
			#1;
		end
		s_rsp_ready = 1'b1;
		#2;
		check_value("s_rsp_valid", s_rsp_valid, 1'b1);
		check_value("s_rsp.rdata", s_rsp.rdata, 32'h11BB_33DD);
		@(posedge clk);
		#1;
		s_rsp_ready = 1'b0;
		send_cmd(read_cmd(32'h1000_0010)); // one slot free again
		s_rsp_ready = 1'b1;
		recv_rsp(r);
		check_value("s_rsp.rdata", r.rdata, 32'h00AD_00EF);
		recv_rsp(r);
		check_value("s_rsp.rdata", r.rdata, 32'h11BB_33DD);
	endtask

	initial begin
		reset = 1'b1;
		s_cmd = '0;
		s_cmd_valid = 1'b0;
		s_rsp_ready = 1'b1;
		// addr, read, wdata, wmask, check rdata, rdata, err
		add_row(32'h1000_0010, 0, 32'h1122_3344, 4'hf, 0, 32'h0, 0);
		add_row(32'h1000_0010, 1, 32'h0, 4'h0, 1, 32'h1122_3344, 0);
		add_row(32'h1000_0010, 0, 32'hAABB_CCDD, 4'h5, 1, 32'h1122_3344, 0); // old word back
		add_row(32'h1000_0010, 1, 32'h0, 4'h0, 1, 32'h11BB_33DD, 0);
		add_row(32'h1000_3FFC, 0, 32'hDEAD_BEEF, 4'hf, 0, 32'h0, 0);
		add_row(32'h1000_3FFC, 1, 32'h0, 4'h0, 1, 32'hDEAD_BEEF, 0);
		add_row(32'h1000_3FFC, 0, 32'h0000_0000, 4'ha, 1, 32'hDEAD_BEEF, 0);
		add_row(32'h1000_3FFC, 1, 32'h0, 4'h0, 1, 32'h00AD_00EF, 0);
		add_row(32'h4000_0020, 0, 32'hCAFE_F00D, 4'hf, 1, 32'h0, 0);
		add_row(32'h4000_0020, 1, 32'h0, 4'h0, 1, 32'hCAFE_F00D, 0);
		add_row(32'h4000_0024, 0, 32'h0000_0000, 4'hf, 1, 32'h0, 0);
		add_row(32'h4000_0024, 0, 32'h1234_5678, 4'hc, 1, 32'h0, 0);
		add_row(32'h4000_0024, 1, 32'h0, 4'h0, 1, 32'h1234_0000, 0);
		add_row(32'h4000_8020, 0, 32'hBAD0_BAD0, 4'hf, 1, 32'h0, 1); // error window
		add_row(32'h4000_8020, 1, 32'h0, 4'h0, 1, 32'h0, 1);
		add_row(32'h4000_0020, 1, 32'h0, 4'h0, 1, 32'hCAFE_F00D, 0);
		add_row(32'hF000_0000, 1, 32'h0, 4'h0, 1, 32'h0, 1); // former PLIC
		add_row(32'hF000_0004, 0, 32'h5555_5555, 4'hf, 1, 32'h0, 1);
		add_row(32'h0FFF_FFFC, 1, 32'h0, 4'h0, 1, 32'h0, 1);
		add_row(32'h1000_4000, 1, 32'h0, 4'h0, 1, 32'h0, 1);
		add_row(32'h4001_0000, 1, 32'h0, 4'h0, 1, 32'h0, 1);
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		#2;
		check_value("s_rsp_valid", s_rsp_valid, 1'b0);
		check_value("m_axi_awvalid", m_axi_awvalid, 1'b0);
		check_value("m_axi_wvalid", m_axi_wvalid, 1'b0);
		check_value("m_axi_arvalid", m_axi_arvalid, 1'b0);
		check_value("m_axi_bready", m_axi_bready, 1'b0);
		check_value("m_axi_rready", m_axi_rready, 1'b0);
		@(posedge clk);
		#1;
		foreach (rows[i]) begin
			send_cmd(rows[i].cmd);
			pause_rsp_ready();
			recv_rsp(rsp);
			if (rows[i].chk_rdata)
				check_value($sformatf("row %0d s_rsp.rdata", i), rsp.rdata, rows[i].exp.rdata);
			check_value($sformatf("row %0d s_rsp.err", i), rsp.err, rows[i].exp.err);
		end
		check_next_cycle_rsp(32'h1000_0010, 32'h11BB_33DD, 1'b0);
		check_next_cycle_rsp(32'hF000_0000, 32'h0, 1'b1);
		check_in_order();
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== verilog.f ====
logic/dbus_pkg.sv
logic/dmem_ram.sv
logic/dmem_ctrler.sv
logic/dbus_router.sv
logic/icb_axil_bridge.sv
logic/dbus_subsys.sv
verification/axil_mem_model.sv
verification/dbus_subsys_tb.sv
